//--- tx_frame_path.f
verilog/tx_path_pkg.sv
verilog/ibuf_ram.sv
verilog/ibuf_writer.sv
verilog/ibuf2mac.sv
verilog/tx_frame_path.sv
verification/mac_tx_model.sv
verification/tx_frame_path_tb.sv

//--- verification/mac_tx_model.sv
`timescale 1ns/1ps

module mac_tx_model
    import tx_path_pkg::*;
(
    input  logic              clk,
    input  logic [QW_W-1:0]   tx_data_i,
    input  logic [QW_W/8-1:0] tx_data_valid_i,
    input  logic              tx_start_i,
    output logic              tx_ack_o,
    input  int                ack_delay_i,      // cycles between qword 0 and ack
    output logic              cap_valid_o,      // one captured qword per cycle
    output logic [QW_W-1:0]   cap_data_o,
    output logic [QW_W/8-1:0] cap_mask_o,
    output logic              bad_o             // sticky handshake violation
);

    logic [QW_W-1:0] first_qw;
    int              wait_cnt;

    // everything sampled on the falling edge, away from the DUT's updates
    initial begin
        tx_ack_o    = 1'b0;
        cap_valid_o = 1'b0;
        cap_data_o  = '0;
        cap_mask_o  = '0;
        bad_o       = 1'b0;
        forever begin
            @(negedge clk);
            cap_valid_o = 1'b0;
            if (tx_start_i) begin
                @(negedge clk);                         // qword 0 now on the bus
                bad_o       = bad_o | tx_start_i;       // start wider than one cycle
                first_qw    = tx_data_i;
                cap_valid_o = 1'b1;
                cap_data_o  = tx_data_i;
                cap_mask_o  = tx_data_valid_i;
                wait_cnt    = ack_delay_i;
                while (wait_cnt > 0) begin
                    @(negedge clk);
                    cap_valid_o = 1'b0;
                    // qword 0 must sit still until ack
                    if (tx_data_i !== first_qw || tx_data_valid_i !== '1) begin
                        bad_o = 1'b1;
                    end
                    wait_cnt--;
                end
                tx_ack_o = 1'b1;
                @(negedge clk);
                tx_ack_o = 1'b0;
                // remaining qwords, one per cycle until valid drops
                while (tx_data_valid_i != '0) begin
                    cap_valid_o = 1'b1;
                    cap_data_o  = tx_data_i;
                    cap_mask_o  = tx_data_valid_i;
                    @(negedge clk);
                end
                cap_valid_o = 1'b0;
            end else if (tx_data_valid_i != '0) begin
                bad_o = 1'b1;                           // lanes valid outside a frame
            end
        end
    end

endmodule

//--- verification/tx_frame_path_tb.sv
`timescale 1ns/1ps

module tx_frame_path_tb
    import tx_path_pkg::*;
();

    localparam int          CLK_PERIOD = 8;
    localparam logic [31:0] SEED       = 32'd12274;
    localparam int          FRAMES     = 45;        // 1 + 8 + 30 + 6
    localparam int          MAX_DELAY  = 20;        // normal ack delay ceiling

    logic                clk;
    logic                rst;
    logic                wb_cyc;
    logic                wb_stb;
    logic                wb_we;
    logic [WB_ADR_W-1:0] wb_adr;
    logic [QW_W-1:0]     wb_dat;
    logic [QW_W-1:0]     wb_dat_o;
    logic                wb_ack;
    logic [QW_W-1:0]     tx_data;
    logic [QW_W/8-1:0]   tx_valid;
    logic                tx_start;
    logic                tx_ack;
    logic                cap_valid;
    logic [QW_W-1:0]     cap_data;
    logic [QW_W/8-1:0]   cap_mask;
    logic                mac_bad;
    logic [7:0]          frame_bytes [2048];    // payload of the frame being sent
    logic [QW_W-1:0]     exp_data [$];
    logic [7:0]          exp_mask [$];
    logic [QW_W-1:0]     rx_data [$];
    logic [7:0]          rx_mask [$];
    logic [31:0]         stim_seed;
    logic [31:0]         dly_seed;              // separate stream for ack delays
    logic                long_delays;
    int                  ack_delay;
    int                  stall_cnt;             // writes that waited on a full buffer
    logic [QW_W-1:0]     rd_qw;

    tx_frame_path UUT (
        .clk             (clk),
        .rst             (rst),
        .wb_cyc_i        (wb_cyc),
        .wb_stb_i        (wb_stb),
        .wb_we_i         (wb_we),
        .wb_adr_i        (wb_adr),
        .wb_dat_i        (wb_dat),
        .wb_dat_o        (wb_dat_o),
        .wb_ack_o        (wb_ack),
        .tx_data_o       (tx_data),
        .tx_data_valid_o (tx_valid),
        .tx_start_o      (tx_start),
        .tx_ack_i        (tx_ack)
    );

    mac_tx_model mac (
        .clk             (clk),
        .tx_data_i       (tx_data),
        .tx_data_valid_i (tx_valid),
        .tx_start_i      (tx_start),
        .tx_ack_o        (tx_ack),
        .ack_delay_i     (ack_delay),
        .cap_valid_o     (cap_valid),
        .cap_data_o      (cap_data),
        .cap_mask_o      (cap_mask),
        .bad_o           (mac_bad)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int rand_below(input int n);
        stim_seed = xorshift(stim_seed);
        return int'(stim_seed % 32'(n));
    endfunction

    // expected qwords with byte i in lane i mod 8 and unused lanes zero
    function automatic void expand_frame(input int len);
        int          k;
        int          b;
        logic [63:0] qw;
        logic [7:0]  mask;
        for (k = 0; k < (len + 7) / 8; k++) begin
            qw   = '0;
            mask = '0;
            for (b = 0; b < 8; b++) begin
                if (k * 8 + b < len) begin
                    qw[b*8 +: 8] = frame_bytes[k*8 + b];
                    mask[b]      = 1'b1;
                end
            end
            exp_data.push_back(qw);
            exp_mask.push_back(mask);                   // full except maybe the last
        end
    endfunction

    task automatic check_val(input logic [63:0] got, input logic [63:0] exp, input string msg);
        if (got !== exp) begin
            $display("ERR @ %0t ns: %s, got %h expected %h", $time, msg, got, exp);
            $display("*** FAILED ***");
            $fatal(1, "value mismatch");
        end
    endtask

    // starts and returns on a falling edge
    task automatic wb_write(input logic [WB_ADR_W-1:0] adr, input logic [QW_W-1:0] dat);
        int waited;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b1;
        wb_adr = adr;
        wb_dat = dat;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!wb_ack);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        if (waited > 2) begin
            stall_cnt++;                                // ack held back beyond the dead cycle
        end
    endtask

    task automatic wb_read(input logic [WB_ADR_W-1:0] adr, output logic [QW_W-1:0] dat);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = adr;
        do begin
            @(negedge clk);
        end while (!wb_ack);
        dat    = wb_dat_o;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    task automatic send_frame(input int len);
        int          i;
        int          k;
        logic [63:0] qw;
        for (i = 0; i < 2048; i++) begin
            frame_bytes[i] = 8'h00;                     // pad lanes stay zero
        end
        for (i = 0; i < len; i++) begin
            frame_bytes[i] = 8'(rand_below(256));
        end
        expand_frame(len);
        for (k = 0; k < (len + 7) / 8; k++) begin
            for (i = 0; i < 8; i++) begin
                qw[i*8 +: 8] = frame_bytes[k*8 + i];
            end
            wb_write(WB_ADR_W'(ADDR_DATA), qw);
        end
        wb_write(WB_ADR_W'(ADDR_COMMIT), 64'(len));
    endtask

    task automatic wait_drained();
        while (exp_data.size() != 0) begin
            @(negedge clk);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // ack delays and comparison
    ////////////////////////////////////////////////////////////

    always @(posedge tx_start) begin
        dly_seed = xorshift(dly_seed);
        if (long_delays) begin
            ack_delay = 400 + int'(dly_seed % 32'd201);     // drains slower than host fills
        end else begin
            ack_delay = int'(dly_seed % 32'(MAX_DELAY + 1));
        end
    end

    always @(posedge clk) begin
        if (cap_valid) begin
            rx_data.push_back(cap_data);
            rx_mask.push_back(cap_mask);
        end
        check_val(64'(mac_bad), 64'd0, "mac handshake or idle lanes");
        while (rx_data.size() != 0) begin
            if (exp_data.size() == 0) begin
                $display("MAC received a qword that no frame accounts for");
                $display("*** FAILED ***");
                $fatal(1, "extra data on the MAC side");
            end else begin
                check_val(rx_data.pop_front(), exp_data.pop_front(), "tx qword");
                check_val(64'(rx_mask.pop_front()), 64'(exp_mask.pop_front()), "lane mask");
            end
        end
    end

    // watchdog
    initial begin
        repeat (FRAMES * 400 + 2000) @(posedge clk);
        $display("timeout: frames not all transmitted");
        $display("*** FAILED ***");
        $fatal(1, "watchdog expired");
    end

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    initial begin
        int i;
        rst         = 1'b1;
        wb_cyc      = 1'b0;
        wb_stb      = 1'b0;
        wb_we       = 1'b0;
        wb_adr      = '0;
        wb_dat      = '0;
        stim_seed   = SEED;
        dly_seed    = ~SEED;
        long_delays = 1'b0;
        ack_delay   = 0;
        stall_cnt   = 0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // mac side stays quiet after reset
        repeat (8) begin
            @(negedge clk);
            check_val(64'({tx_start, tx_valid}), 64'd0, "mac outputs after reset");
        end
        // all but the header slot free
        wb_read(WB_ADR_W'(ADDR_STATUS), rd_qw);
        check_val(rd_qw, 64'(IBUF_DEPTH - 1), "free count after reset");

        send_frame(60);
        for (i = 0; i < 8; i++) begin
            send_frame(64 + 9 * i);                     // every residue mod 8
        end
        for (i = 0; i < 30; i++) begin
            send_frame(60 + rand_below(1455));
        end
        wait_drained();

        // slow mac lets the host outrun the buffer
        long_delays = 1'b1;
        stall_cnt   = 0;
        for (i = 0; i < 6; i++) begin
            send_frame(1514);
        end
        wait_drained();
        check_val(64'(stall_cnt != 0), 64'd1, "data writes back-pressured");
        wb_read(WB_ADR_W'(ADDR_STATUS), rd_qw);
        check_val(rd_qw, 64'(IBUF_DEPTH - 1), "free count after drain");

        $display("*** PASSED ***");
        $finish;
    end

endmodule

//--- verilog/ibuf2mac.sv
`timescale 1ns/1ps

module ibuf2mac
    import tx_path_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    // ram read port
    output logic [IBUF_AW-1:0] rd_addr_o,
    input  logic [QW_W-1:0]    rd_data_i,
    // pointer exchange with the writer
    input  logic [PTR_W-1:0]   committed_prod_i,
    output logic [PTR_W-1:0]   committed_cons_o,
    // mac tx
    output logic [QW_W-1:0]    tx_data_o,
    output logic [QW_W/8-1:0]  tx_data_valid_o,
    output logic               tx_start_o,
    input  logic               tx_ack_i
);

    typedef enum logic [2:0] {
        SY_IDLE, SY_HDR, SY_PARSE, SY_CHECK, SY_ARMED
    } sync_state_t;

    typedef enum logic [2:0] {
        SN_IDLE, SN_PRE, SN_LOAD0, SN_LOAD1, SN_HOLD, SN_STREAM, SN_DONE
    } send_state_t;

    sync_state_t        sy_st;
    send_state_t        sn_st;

    logic [LEN_W-1:0]   len;        // header byte length
    logic [LEN_W-3:0]   qw_cnt;     // qwords in the frame
    logic [QW_W/8-1:0]  lst_ben;    // lanes of the last qword
    logic [PTR_W-1:0]   avail;      // committed qwords ahead of us
    logic               trig;
    logic [PTR_W-1:0]   rd_ptr;
    logic [PTR_W-1:0]   nxt_cons;   // header slot of the next frame
    logic [QW_W-1:0]    aux_qw;     // qword 1 parked while waiting for ack
    logic [LEN_W-3:0]   qw_snt;     // qwords handed to the mac

    assign rd_addr_o = rd_ptr[IBUF_AW-1:0];
    assign avail     = committed_prod_i - committed_cons_o;
    assign nxt_cons  = committed_cons_o + PTR_W'(qw_cnt) + PTR_W'(1);

    ////////////////////////////////////////////////////////////
    // frame sync
    ////////////////////////////////////////////////////////////
    // rd_ptr rests on the header slot whenever the sender is idle

    always_ff @(posedge clk) begin
        if (rst) begin
            sy_st <= SY_IDLE;
            trig  <= 1'b0;
        end else begin
            trig <= 1'b0;
            case (sy_st)
                SY_IDLE: begin
                    if (avail != '0) begin          // header slot now written
                        sy_st <= SY_HDR;
                    end
                end
                SY_HDR: begin
                    len   <= rd_data_i[HDR_LEN_LSB +: LEN_W];
                    sy_st <= SY_PARSE;
                end
                SY_PARSE: begin
                    // round up to whole qwords
                    qw_cnt <= {1'b0, len[LEN_W-1:3]} + (LEN_W-2)'(len[2:0] != 3'd0);
                    if (len[2:0] == 3'd0) begin
                        lst_ben <= '1;
                    end else begin
                        lst_ben <= (QW_W/8)'((9'd1 << len[2:0]) - 9'd1);
                    end
                    sy_st <= SY_CHECK;
                end
                SY_CHECK: begin
                    // header plus every data qword committed
                    if ((LEN_W-2)'(avail) > qw_cnt) begin
                        trig  <= 1'b1;
                        sy_st <= SY_ARMED;
                    end
                end
                SY_ARMED: begin
                    if (sn_st == SN_DONE) begin
                        sy_st <= SY_IDLE;
                    end
                end
                default: begin
                    sy_st <= SY_IDLE;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // send
    ////////////////////////////////////////////////////////////
    // read pipe runs two qwords ahead of tx_data_o

    always_ff @(posedge clk) begin
        if (rst) begin
            sn_st            <= SN_IDLE;
            tx_start_o       <= 1'b0;
            tx_data_valid_o  <= '0;
            rd_ptr           <= '0;
            committed_cons_o <= '0;
        end else begin
            tx_start_o      <= 1'b0;
            tx_data_valid_o <= '0;
            case (sn_st)
                SN_IDLE: begin
                    if (trig) begin
                        rd_ptr <= committed_cons_o + PTR_W'(1);   // qword 0
                        sn_st  <= SN_PRE;
                    end
                end
                SN_PRE: begin
                    rd_ptr     <= rd_ptr + PTR_W'(1);
                    tx_start_o <= 1'b1;
                    sn_st      <= SN_LOAD0;
                end
                SN_LOAD0: begin
                    tx_data_o       <= rd_data_i;   // qword 0 shown until ack
                    tx_data_valid_o <= '1;
                    rd_ptr          <= rd_ptr + PTR_W'(1);
                    sn_st           <= SN_LOAD1;
                end
                SN_LOAD1: begin
                    tx_data_valid_o <= '1;
                    if (tx_ack_i) begin             // early ack, take qword 1 straight
                        tx_data_o <= rd_data_i;
                        rd_ptr    <= rd_ptr + PTR_W'(1);
                        qw_snt    <= (LEN_W-2)'(2);
                        sn_st     <= SN_STREAM;
                    end else begin
                        aux_qw <= rd_data_i;
                        sn_st  <= SN_HOLD;
                    end
                end
                SN_HOLD: begin
                    tx_data_valid_o <= '1;
                    if (tx_ack_i) begin
                        tx_data_o <= aux_qw;
                        rd_ptr    <= rd_ptr + PTR_W'(1);
                        qw_snt    <= (LEN_W-2)'(2);
                        sn_st     <= SN_STREAM;
                    end
                end
                SN_STREAM: begin
                    // no stall once the mac has acked
                    tx_data_o       <= rd_data_i;
                    tx_data_valid_o <= '1;
                    rd_ptr          <= rd_ptr + PTR_W'(1);
                    qw_snt          <= qw_snt + (LEN_W-2)'(1);
                    if (qw_snt == qw_cnt - (LEN_W-2)'(1)) begin
                        tx_data_valid_o <= lst_ben;
                        sn_st           <= SN_DONE;
                    end
                end
                SN_DONE: begin
                    // last qword on the bus this cycle
                    committed_cons_o <= nxt_cons;
                    rd_ptr           <= nxt_cons;
                    sn_st            <= SN_IDLE;
                end
                default: begin
                    sn_st <= SN_IDLE;
                end
            endcase
        end
    end

endmodule

//--- verilog/ibuf_ram.sv
`timescale 1ns/1ps

module ibuf_ram
    import tx_path_pkg::*;
(
    input  logic               clk,
    // write side, owned by the wishbone writer
    input  logic               wr_en_i,
    input  logic [IBUF_AW-1:0] wr_addr_i,
    input  logic [QW_W-1:0]    wr_data_i,
    // read side, owned by the frame sender
    input  logic [IBUF_AW-1:0] rd_addr_i,
    output logic [QW_W-1:0]    rd_data_o
);

    // circular qword store
    logic [QW_W-1:0] mem [IBUF_DEPTH];

    ////////////////////////////////////////////////////////////
    // write port
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    ////////////////////////////////////////////////////////////
    // registered read port
    ////////////////////////////////////////////////////////////
    // data one cycle after address, old word on a same-address hit
    always_ff @(posedge clk) begin
        rd_data_o <= mem[rd_addr_i];
    end

endmodule

//--- verilog/ibuf_writer.sv
`timescale 1ns/1ps

module ibuf_writer
    import tx_path_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    // wishbone classic slave
    input  logic                wb_cyc_i,
    input  logic                wb_stb_i,
    input  logic                wb_we_i,
    input  logic [WB_ADR_W-1:0] wb_adr_i,
    input  logic [QW_W-1:0]     wb_dat_i,
    output logic [QW_W-1:0]     wb_dat_o,
    output logic                wb_ack_o,
    // pointer exchange with the sender
    input  logic [PTR_W-1:0]    committed_cons_i,
    output logic [PTR_W-1:0]    committed_prod_o,
    // ram write port
    output logic                wr_en_o,
    output logic [IBUF_AW-1:0]  wr_addr_o,
    output logic [QW_W-1:0]     wr_data_o
);

    logic [PTR_W-1:0] sof_ptr;      // header slot of the frame being filled
    logic [PTR_W-1:0] wr_ptr;       // next data slot
    logic [PTR_W-1:0] used_cnt;     // qwords not yet freed by the sender
    logic [PTR_W-1:0] free_cnt;
    logic [QW_W-1:0]  hdr_qw;
    logic             live;
    logic             is_data;
    logic             is_commit;
    logic             is_status;
    logic             room;
    logic             has_data;
    logic             data_wr;
    logic             commit_wr;

    ////////////////////////////////////////////////////////////
    // decode
    ////////////////////////////////////////////////////////////

    // cycle right after an ack is never taken, so a held stb counts once
    assign live      = wb_cyc_i && wb_stb_i && !wb_ack_o;
    assign is_data   = (wb_adr_i == WB_ADR_W'(ADDR_DATA));
    assign is_commit = (wb_adr_i == WB_ADR_W'(ADDR_COMMIT));
    assign is_status = (wb_adr_i == WB_ADR_W'(ADDR_STATUS));

    // free space seen from the write pointer
    assign used_cnt = wr_ptr - committed_cons_i;        // wraps mod 2*depth
    assign free_cnt = PTR_W'(IBUF_DEPTH) - used_cnt;
    assign room     = (free_cnt >= PTR_W'(2));          // keep one for next header

    // commit with an empty frame does nothing
    assign has_data = (wr_ptr != sof_ptr + PTR_W'(1));

    assign data_wr   = live && wb_we_i && is_data && room;
    assign commit_wr = live && wb_we_i && is_commit && has_data;

    ////////////////////////////////////////////////////////////
    // ram write port
    ////////////////////////////////////////////////////////////

    always_comb begin
        hdr_qw = '0;
        hdr_qw[HDR_LEN_LSB +: LEN_W] = wb_dat_i[LEN_W-1:0];   // byte length
    end

    assign wr_en_o   = data_wr || commit_wr;
    assign wr_addr_o = commit_wr ? sof_ptr[IBUF_AW-1:0] : wr_ptr[IBUF_AW-1:0];
    assign wr_data_o = commit_wr ? hdr_qw : wb_dat_i;

    ////////////////////////////////////////////////////////////
    // ack and pointers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack_o         <= 1'b0;
            sof_ptr          <= '0;
            wr_ptr           <= PTR_W'(1);          // slot 0 held for first header
            committed_prod_o <= '0;
        end else begin
            wb_ack_o <= 1'b0;
            if (live) begin
                if (is_data && wb_we_i) begin
                    wb_ack_o <= room;               // stall host while full
                end else begin
                    wb_ack_o <= 1'b1;
                end
            end

            if (data_wr) begin
                wr_ptr <= wr_ptr + PTR_W'(1);
            end

            // publish frame, open next header slot
            if (commit_wr) begin
                committed_prod_o <= wr_ptr;         // one past last data qword
                sof_ptr          <= wr_ptr;
                wr_ptr           <= wr_ptr + PTR_W'(1);
            end
        end
    end

    // read data, only status has content
    always_ff @(posedge clk) begin
        if (live && !wb_we_i) begin
            wb_dat_o <= is_status ? QW_W'(free_cnt) : '0;
        end
    end

endmodule

//--- verilog/tx_frame_path.sv
`timescale 1ns/1ps

module tx_frame_path
    import tx_path_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    // wishbone classic slave
    input  logic                wb_cyc_i,
    input  logic                wb_stb_i,
    input  logic                wb_we_i,
    input  logic [WB_ADR_W-1:0] wb_adr_i,
    input  logic [QW_W-1:0]     wb_dat_i,
    output logic [QW_W-1:0]     wb_dat_o,
    output logic                wb_ack_o,
    // mac tx
    output logic [QW_W-1:0]     tx_data_o,
    output logic [QW_W/8-1:0]   tx_data_valid_o,
    output logic                tx_start_o,
    input  logic                tx_ack_i
);

    ////////////////////////////////////////////////////////////
    // inner wiring
    ////////////////////////////////////////////////////////////

    logic               wr_en;
    logic [IBUF_AW-1:0] wr_addr;
    logic [QW_W-1:0]    wr_data;
    logic [IBUF_AW-1:0] rd_addr;
    logic [QW_W-1:0]    rd_data;
    logic [PTR_W-1:0]   committed_prod;     // writer to sender
    logic [PTR_W-1:0]   committed_cons;     // sender to writer

    // host side, fills the buffer
    ibuf_writer u_writer (
        .clk              (clk),
        .rst              (rst),
        .wb_cyc_i         (wb_cyc_i),
        .wb_stb_i         (wb_stb_i),
        .wb_we_i          (wb_we_i),
        .wb_adr_i         (wb_adr_i),
        .wb_dat_i         (wb_dat_i),
        .wb_dat_o         (wb_dat_o),
        .wb_ack_o         (wb_ack_o),
        .committed_cons_i (committed_cons),
        .committed_prod_o (committed_prod),
        .wr_en_o          (wr_en),
        .wr_addr_o        (wr_addr),
        .wr_data_o        (wr_data)
    );

    ibuf_ram u_ram (
        .clk       (clk),
        .wr_en_i   (wr_en),
        .wr_addr_i (wr_addr),
        .wr_data_i (wr_data),
        .rd_addr_i (rd_addr),
        .rd_data_o (rd_data)
    );

    // mac side, drains whole frames
    ibuf2mac u_sender (
        .clk              (clk),
        .rst              (rst),
        .rd_addr_o        (rd_addr),
        .rd_data_i        (rd_data),
        .committed_prod_i (committed_prod),
        .committed_cons_o (committed_cons),
        .tx_data_o        (tx_data_o),
        .tx_data_valid_o  (tx_data_valid_o),
        .tx_start_o       (tx_start_o),
        .tx_ack_i         (tx_ack_i)
    );

endmodule

//--- verilog/tx_path_pkg.sv
package tx_path_pkg;

    ////////////////////////////////////////////////////////////
    // buffer geometry
    ////////////////////////////////////////////////////////////

    localparam int IBUF_AW    = 9;              // qword address bits
    localparam int IBUF_DEPTH = 2 ** IBUF_AW;   // 512 qwords
    localparam int PTR_W      = IBUF_AW + 1;    // extra msb tells full from empty
    localparam int QW_W       = 64;             // one qword per ram word

    ////////////////////////////////////////////////////////////
    // header qword layout
    ////////////////////////////////////////////////////////////

    // header sits in the slot just before the first data qword
    localparam int LEN_W       = 16;            // frame byte length
    localparam int HDR_LEN_LSB = 32;            // length lives in bits 47:32

    ////////////////////////////////////////////////////////////
    // wishbone register map
    ////////////////////////////////////////////////////////////

    localparam int WB_ADR_W = 2;                // word address bits

    // data port, one frame qword per write
    localparam int ADDR_DATA   = 0;

    // commit, byte length in the low 16 bits
    localparam int ADDR_COMMIT = 1;

    // status, free qword count on read
    localparam int ADDR_STATUS = 2;

endpackage
